//--- Makefile
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module dcache_tb

sim:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module dcache_tb -Mdir obj_dir
	./obj_dir/Vdcache_tb | tee $(LOG)
	@if grep -q "TEST PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- rtl/axi_line_master.sv
`timescale 1ns/1ns
`default_nettype none

module axi_line_master #(
    parameter int LINE_WORDS_LOG = dcache_pkg::DEF_LINE_WORDS_LOG,
    parameter int INDEX_BITS = dcache_pkg::DEF_INDEX_BITS
) (
    input wire clk,
    input wire rst,
    input wire fill_start,
    input wire evict_start,
    input wire dcache_pkg::addr_t line_addr,
    input wire dcache_pkg::addr_t victim_addr,
    input wire victim_way,
    input wire dcache_pkg::word_t wb_data,
    output logic wb_rd_en,
    output logic wb_way,
    output logic [INDEX_BITS-1:0] wb_index,
    output logic [LINE_WORDS_LOG-1:0] wb_word,
    output logic fill_valid,
    output logic [LINE_WORDS_LOG-1:0] fill_word_idx,
    output dcache_pkg::word_t fill_data,
    output logic fill_done,
    output logic evict_done,
    output logic ar_valid,
    output dcache_pkg::axi_addr_t ar,
    input wire ar_ready,
    input wire r_valid,
    input wire dcache_pkg::axi_r_t r,
    output logic r_ready,
    output logic aw_valid,
    output dcache_pkg::axi_addr_t aw,
    input wire aw_ready,
    output logic w_valid,
    output dcache_pkg::axi_w_t w,
    input wire w_ready,
    input wire b_valid
);
    import dcache_pkg::*;

    localparam int LINE_WORDS = 1 << LINE_WORDS_LOG;
    localparam logic [7:0] BURST_LEN = 8'(LINE_WORDS - 1);

    typedef enum logic [2:0] {m_idle, m_copy, m_aw, m_w, m_b, m_ar, m_r} line_state_t;

    line_state_t st;
    addr_t job_addr;
    logic job_way;
    logic [LINE_WORDS_LOG:0] copy_cnt;
    logic [LINE_WORDS_LOG-1:0] beat;
    word_t line_buf [LINE_WORDS];

    assign ar_valid = st == m_ar;
    assign ar.addr = job_addr;
    assign ar.len = BURST_LEN;
    assign r_ready = st == m_r;
    assign aw_valid = st == m_aw;
    assign aw.addr = job_addr;
    assign aw.len = BURST_LEN;
    assign w_valid = st == m_w;
    assign w.data = line_buf[beat];
    assign w.strb = 4'hf;
    assign w.last = &beat;

    // victim read port, data arrives one cycle after the address
    assign wb_rd_en = st == m_copy && !copy_cnt[LINE_WORDS_LOG];
    assign wb_way = job_way;
    assign wb_index = job_addr[LINE_WORDS_LOG + 2 +: INDEX_BITS];
    assign wb_word = copy_cnt[LINE_WORDS_LOG-1:0];

    assign fill_valid = st == m_r && r_valid;
    assign fill_word_idx = beat;
    assign fill_data = r.data;
    assign fill_done = fill_valid && r.last;
    assign evict_done = st == m_b && b_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            st <= m_idle;
            copy_cnt <= '0;
            beat <= '0;
        end else begin
            case (st)
                m_copy: begin
                    copy_cnt <= copy_cnt + 1'b1;
                    if (copy_cnt[LINE_WORDS_LOG]) st <= m_aw;
                end
                m_aw: if (aw_ready) st <= m_w;
                m_w: begin
                    if (w_ready) begin
                        beat <= beat + 1'b1;
                        if (&beat) st <= m_b;
                    end
                end
                m_b: if (b_valid) st <= m_idle;
                m_ar: if (ar_ready) st <= m_r;
                m_r: begin
                    if (r_valid) begin
                        beat <= beat + 1'b1;
                        if (r.last) st <= m_idle;
                    end
                end
                default: ;
            endcase
            // new jobs; a refill may follow the B beat directly
            if (evict_start) begin
                st <= m_copy;
                copy_cnt <= '0;
            end
            if (fill_start) begin
                st <= m_ar;
                beat <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (evict_start) begin
            job_addr <= victim_addr;
            job_way <= victim_way;
        end
        if (fill_start) begin
            job_addr <= line_addr;
        end
        if (st == m_copy && copy_cnt != '0) begin
            line_buf[LINE_WORDS_LOG'(copy_cnt - 1'b1)] <= wb_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl #(
    parameter int LINE_WORDS_LOG = dcache_pkg::DEF_LINE_WORDS_LOG,
    parameter int INDEX_BITS = dcache_pkg::DEF_INDEX_BITS,
    localparam int TAG_BITS = 32 - INDEX_BITS - LINE_WORDS_LOG - 2
) (
    input wire clk,
    input wire rst,
    input wire req_valid,
    input wire dcache_pkg::cpu_req_t req,
    output logic stall,
    output logic rsp_valid,
    output dcache_pkg::word_t rdata,
    // meta and data ram
    input wire [1:0][TAG_BITS-1:0] way_tag,
    input wire [1:0] way_valid,
    input wire [1:0] way_dirty,
    input wire lru_way,
    input wire dcache_pkg::word_t [1:0] way_data,
    output logic rd_en,
    output logic [INDEX_BITS-1:0] rd_index,
    output logic [LINE_WORDS_LOG-1:0] rd_word,
    output logic [INDEX_BITS-1:0] wr_index,
    output logic [LINE_WORDS_LOG-1:0] wr_word,
    output logic wr_way,
    output dcache_pkg::strb_t wr_strb,
    output dcache_pkg::word_t wr_data,
    output logic [1:0] tag_wr_way,
    output logic [TAG_BITS-1:0] wr_tag,
    output logic [1:0] set_valid_way,
    output logic [1:0] set_dirty_way,
    output logic [1:0] clr_dirty_way,
    output logic touch_en,
    output logic touch_way,
    // line engine
    input wire fill_valid,
    input wire [LINE_WORDS_LOG-1:0] fill_word_idx,
    input wire dcache_pkg::word_t fill_data,
    input wire fill_done,
    input wire evict_done,
    output logic fill_start,
    output logic evict_start,
    output dcache_pkg::addr_t line_addr,
    output dcache_pkg::addr_t victim_addr,
    output logic victim_way
);
    import dcache_pkg::*;

    localparam int OFFSET = LINE_WORDS_LOG + 2;

    typedef logic [TAG_BITS-1:0] tag_t;

    ctrl_state_t state;
    logic lk_valid;
    cpu_req_t lk;
    word_t fill_word_q;
    tag_t lk_tag;
    logic [INDEX_BITS-1:0] lk_index;
    logic [LINE_WORDS_LOG-1:0] lk_word;
    logic [1:0] hit_way, victim_oh;
    logic hit, hit_now, miss, store_hit, victim_dirty, fill_end, fill_hit_word;

    assign lk_tag = lk.addr[31 -: TAG_BITS];
    assign lk_index = lk.addr[OFFSET +: INDEX_BITS];
    assign lk_word = lk.addr[2 +: LINE_WORDS_LOG];

    assign hit_way = {way_valid[1] && way_tag[1] == lk_tag, way_valid[0] && way_tag[0] == lk_tag};
    assign hit = |hit_way;
    assign hit_now = state == idle && lk_valid && hit;
    assign miss = state == idle && lk_valid && !hit;
    assign store_hit = hit_now && lk.write;
    assign victim_oh = lru_way ? 2'b10 : 2'b01;
    assign victim_dirty = |(victim_oh & way_valid & way_dirty);
    assign fill_end = state == refill && fill_done;
    assign fill_hit_word = fill_valid && fill_word_idx == lk_word;

    // cpu side
    assign stall = miss || state == writeback || state == refill;
    assign rsp_valid = hit_now || state == respond;
    assign rdata = (state == respond) ? fill_word_q : way_data[hit_way[1]];
    assign rd_en = req_valid && !stall;
    assign rd_index = req.addr[OFFSET +: INDEX_BITS];
    assign rd_word = req.addr[2 +: LINE_WORDS_LOG];

    // bank writes: store hit, or refill beats with the pending store merged
    assign wr_index = lk_index;
    assign wr_word = (state == refill) ? fill_word_idx : lk_word;
    assign wr_way = (state == refill) ? lru_way : hit_way[1];
    assign wr_strb = store_hit ? lk.strb : (state == refill && fill_valid) ? 4'hf : 4'h0;
    assign wr_data = (state != refill) ? lk.wdata :
                     (fill_hit_word && lk.write) ? byte_merge(fill_data, lk.wdata, lk.strb) :
                     fill_data;

    // meta updates
    assign tag_wr_way = fill_end ? victim_oh : 2'b00;
    assign wr_tag = lk_tag;
    assign set_valid_way = tag_wr_way;
    assign set_dirty_way = (store_hit ? hit_way : 2'b00) |
                           ((fill_end && lk.write) ? victim_oh : 2'b00);
    assign clr_dirty_way = (fill_end && !lk.write) ? victim_oh : 2'b00;
    assign touch_en = hit_now || fill_end;
    assign touch_way = fill_end ? lru_way : hit_way[1];

    // line jobs, write-back first when the victim is dirty
    assign evict_start = miss && victim_dirty;
    assign fill_start = (miss && !victim_dirty) || (state == writeback && evict_done);
    assign line_addr = {lk_tag, lk_index, {OFFSET{1'b0}}};
    assign victim_addr = {way_tag[lru_way], lk_index, {OFFSET{1'b0}}};
    assign victim_way = lru_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            lk_valid <= 1'b0;
        end else begin
            if (!stall) begin
                lk_valid <= req_valid;
            end
            case (state)
                idle: if (miss) state <= victim_dirty ? writeback : refill;
                writeback: if (evict_done) state <= refill;
                refill: if (fill_done) state <= respond;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            lk <= req;
        end
        // requested word for the load answer
        if (state == refill && fill_hit_word) begin
            fill_word_q <= fill_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/dcache_data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_data_ram #(
    parameter int LINE_WORDS_LOG = dcache_pkg::DEF_LINE_WORDS_LOG,
    parameter int INDEX_BITS = dcache_pkg::DEF_INDEX_BITS
) (
    input wire clk,
    input wire rd_en,
    input wire [INDEX_BITS-1:0] rd_index,
    input wire [LINE_WORDS_LOG-1:0] rd_word,
    input wire [INDEX_BITS-1:0] wr_index,
    input wire [LINE_WORDS_LOG-1:0] wr_word,
    input wire wr_way,
    input wire dcache_pkg::strb_t wr_strb,
    input wire dcache_pkg::word_t wr_data,
    input wire wb_rd_en,
    input wire wb_way,
    input wire [INDEX_BITS-1:0] wb_index,
    input wire [LINE_WORDS_LOG-1:0] wb_word,
    output dcache_pkg::word_t [1:0] way_data,
    output dcache_pkg::word_t wb_data
);
    import dcache_pkg::*;

    localparam int AW = INDEX_BITS + LINE_WORDS_LOG;
    localparam int DEPTH = 1 << AW;

    word_t mem [2][DEPTH];
    logic [AW-1:0] rd_addr, wr_addr;

    assign rd_addr = {rd_index, rd_word};
    assign wr_addr = {wr_index, wr_word};

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (wr_strb[b]) begin
                mem[wr_way][wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
        // bypass so a load right behind a store sees it
        for (int i = 0; i < 2; i++) begin
            if (rd_en) begin
                way_data[i] <= byte_merge(mem[i][rd_addr], wr_data,
                    (wr_way == 1'(i) && wr_addr == rd_addr) ? wr_strb : 4'b0000);
            end
        end
        if (wb_rd_en) begin
            wb_data <= mem[wb_way][{wb_index, wb_word}];
        end
    end

endmodule

`default_nettype wire

//--- rtl/dcache_meta.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_meta #(
    parameter int LINE_WORDS_LOG = dcache_pkg::DEF_LINE_WORDS_LOG,
    parameter int INDEX_BITS = dcache_pkg::DEF_INDEX_BITS,
    localparam int TAG_BITS = 32 - INDEX_BITS - LINE_WORDS_LOG - 2
) (
    input wire clk,
    input wire rst,
    input wire rd_en,
    input wire [INDEX_BITS-1:0] rd_index,
    input wire [INDEX_BITS-1:0] wr_index,
    input wire [1:0] tag_wr_way,
    input wire [TAG_BITS-1:0] wr_tag,
    input wire [1:0] set_valid_way,
    input wire [1:0] set_dirty_way,
    input wire [1:0] clr_dirty_way,
    input wire touch_en,
    input wire touch_way,
    output logic [1:0][TAG_BITS-1:0] way_tag,
    output logic [1:0] way_valid,
    output logic [1:0] way_dirty,
    output logic lru_way
);
    localparam int SETS = 1 << INDEX_BITS;

    logic [SETS-1:0][1:0] valid_q;
    logic [SETS-1:0][1:0] dirty_q;
    logic [SETS-1:0] lru_q;
    logic [1:0] valid_nxt, dirty_nxt;
    logic lru_nxt;
    logic same_set;

    // updated flags of the set being written
    assign valid_nxt = valid_q[wr_index] | set_valid_way;
    assign dirty_nxt = (dirty_q[wr_index] & ~clr_dirty_way) | set_dirty_way;
    assign lru_nxt = touch_en ? ~touch_way : lru_q[wr_index];
    assign same_set = rd_index == wr_index;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q <= '0;
            way_valid <= '0;
            way_dirty <= '0;
            lru_way <= 1'b0;
        end else begin
            valid_q[wr_index] <= valid_nxt;
            dirty_q[wr_index] <= dirty_nxt;
            lru_q[wr_index] <= lru_nxt;
            // write-first when reading the set being updated
            if (rd_en) begin
                way_valid <= same_set ? valid_nxt : valid_q[rd_index];
                way_dirty <= same_set ? dirty_nxt : dirty_q[rd_index];
                lru_way <= same_set ? lru_nxt : lru_q[rd_index];
            end
        end
    end

    for (genvar i = 0; i < 2; i++) begin : g_tag
        logic [TAG_BITS-1:0] tag_mem [SETS];
        logic [TAG_BITS-1:0] tag_q;

        always_ff @(posedge clk) begin
            if (tag_wr_way[i]) begin
                tag_mem[wr_index] <= wr_tag;
            end
            if (rd_en) begin
                tag_q <= (tag_wr_way[i] && same_set) ? wr_tag : tag_mem[rd_index];
            end
        end

        assign way_tag[i] = tag_q;
    end

endmodule

`default_nettype wire

//--- rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0] strb_t;

    // cpu request, strb ignored on loads
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        strb_t strb;
        logic write;
    } cpu_req_t;

    // shared by AR and AW
    typedef struct packed {
        addr_t addr;
        logic [7:0] len;
    } axi_addr_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
        logic last;
    } axi_w_t;

    typedef struct packed {
        word_t data;
        logic last;
    } axi_r_t;

    typedef enum logic [1:0] {
        idle,
        writeback,
        refill,
        respond
    } ctrl_state_t;

    localparam int DEF_LINE_WORDS_LOG = 3;
    localparam int DEF_INDEX_BITS = 7;

    // replace the strobed bytes of old_word with those of new_word
    function automatic word_t byte_merge(word_t old_word, word_t new_word, strb_t strb);
        word_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

//--- rtl/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top #(
    parameter int LINE_WORDS_LOG = dcache_pkg::DEF_LINE_WORDS_LOG,
    parameter int INDEX_BITS = dcache_pkg::DEF_INDEX_BITS,
    localparam int TAG_BITS = 32 - INDEX_BITS - LINE_WORDS_LOG - 2
) (
    input wire clk,
    input wire rst,
    // cpu port
    input wire req_valid,
    input wire dcache_pkg::cpu_req_t req,
    output logic stall,
    output logic rsp_valid,
    output dcache_pkg::word_t rdata,
    // AXI4 master port
    output logic ar_valid,
    output dcache_pkg::axi_addr_t ar,
    input wire ar_ready,
    input wire r_valid,
    input wire dcache_pkg::axi_r_t r,
    output logic r_ready,
    output logic aw_valid,
    output dcache_pkg::axi_addr_t aw,
    input wire aw_ready,
    output logic w_valid,
    output dcache_pkg::axi_w_t w,
    input wire w_ready,
    input wire b_valid
);
    import dcache_pkg::*;

    // lookup side
    logic rd_en;
    logic [INDEX_BITS-1:0] rd_index, wr_index, wb_index;
    logic [LINE_WORDS_LOG-1:0] rd_word, wr_word, wb_word, fill_word_idx;
    logic [1:0] tag_wr_way, set_valid_way, set_dirty_way, clr_dirty_way;
    logic [1:0] way_valid, way_dirty;
    logic [1:0][TAG_BITS-1:0] way_tag;
    logic [TAG_BITS-1:0] wr_tag;
    logic touch_en, touch_way, lru_way, wr_way;
    strb_t wr_strb;
    word_t wr_data;
    word_t [1:0] way_data;

    // line engine side
    logic wb_rd_en, wb_way;
    word_t wb_data, fill_data;
    logic fill_start, evict_start, victim_way;
    addr_t line_addr, victim_addr;
    logic fill_valid, fill_done, evict_done;

    dcache_ctrl #(.LINE_WORDS_LOG(LINE_WORDS_LOG), .INDEX_BITS(INDEX_BITS)) u_ctrl (.*);

    dcache_meta #(.LINE_WORDS_LOG(LINE_WORDS_LOG), .INDEX_BITS(INDEX_BITS)) u_meta (.*);

    dcache_data_ram #(.LINE_WORDS_LOG(LINE_WORDS_LOG), .INDEX_BITS(INDEX_BITS)) u_data (.*);

    axi_line_master #(.LINE_WORDS_LOG(LINE_WORDS_LOG), .INDEX_BITS(INDEX_BITS)) u_axi (.*);

endmodule

`default_nettype wire

//--- sim.f
rtl/dcache_pkg.sv
rtl/dcache_meta.sv
rtl/dcache_data_ram.sv
rtl/dcache_ctrl.sv
rtl/axi_line_master.sv
rtl/dcache_top.sv
verification/dcache_checker.sv
verification/dcache_assert.sv
verification/dcache_tb.sv

//--- verification/dcache_assert.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_assert (
    input wire clk,
    input wire rst,
    input wire req_valid,
    input wire stall,
    input wire ar_valid,
    input wire ar_ready,
    input wire dcache_pkg::axi_addr_t ar,
    input wire aw_valid,
    input wire aw_ready,
    input wire dcache_pkg::axi_addr_t aw,
    input wire w_valid,
    input wire w_ready,
    input wire dcache_pkg::axi_w_t w
);
    import dcache_pkg::*;

    localparam logic [7:0] LAST_BEAT = 8'((1 << DEF_LINE_WORDS_LOG) - 1);

    logic [7:0] w_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            w_cnt <= '0;
        end else if (w_valid && w_ready) begin
            w_cnt <= w.last ? 8'd0 : w_cnt + 8'd1;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar)) else $error("ar dropped early");
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw)) else $error("aw dropped early");
    w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w)) else $error("w dropped early");
    // a stall always follows an accepted request
    stall_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(stall) |-> $past(req_valid)) else $error("stall without a request");
    w_last_pos: assert property (@(posedge clk) disable iff (rst)
        w_valid |-> (w.last == (w_cnt == LAST_BEAT))) else $error("w.last misplaced");

endmodule

bind dcache_top dcache_assert asrt_i (.*);

`default_nettype wire

//--- verification/dcache_checker.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_checker (
    input wire clk,
    input wire rst,
    input wire req_valid,
    input wire dcache_pkg::cpu_req_t req,
    input wire stall,
    input wire rsp_valid,
    input wire dcache_pkg::word_t rdata,
    input wire ar_valid,
    input wire ar_ready,
    input wire dcache_pkg::axi_addr_t ar,
    input wire r_ready,
    input wire aw_valid,
    input wire aw_ready,
    input wire dcache_pkg::axi_addr_t aw,
    input wire w_valid,
    input wire w_ready,
    input wire dcache_pkg::axi_w_t w,
    output int err_count,
    output int check_count,
    output int pending
);
    import dcache_pkg::*;

    localparam int LINE_WORDS = 1 << DEF_LINE_WORDS_LOG;
    localparam int LINE_BYTES = LINE_WORDS * 4;

    word_t model [addr_t];
    word_t exp_q [$];
    logic load_q [$];
    logic fast_q [$];
    longint cyc_q [$];
    longint cycle;
    addr_t wb_addr;
    int wb_beat;
    logic seen_req, prev_ok;
    logic [31:0] prev_line;

    function automatic word_t model_word(addr_t a);
        if (model.exists(a)) return model[a];
        return a ^ 32'hA5A5A5A5;
    endfunction

    // bytes with strobe set come from the new word
    function automatic word_t apply_strobe(word_t cur, word_t nw, strb_t s);
        word_t mask;
        mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
        return (cur & ~mask) | (nw & mask);
    endfunction

    assign pending = exp_q.size();

    initial begin
        err_count = 0;
        check_count = 0;
        cycle = 0;
        seen_req = 1'b0;
        prev_ok = 1'b0;
        prev_line = '0;
        wb_addr = '0;
        wb_beat = 0;
    end

    always @(posedge clk) begin
        word_t e;
        logic ld;
        logic fast;
        longint c;
        addr_t wa;
        cycle++;
        if (!rst) begin
            if (req_valid) seen_req = 1'b1;
            if (!seen_req && (stall || rsp_valid || ar_valid || aw_valid
                    || w_valid || r_ready)) begin
                $display("DUT drove a handshake output before the first request at %0t", $time);
                err_count++;
            end
            // a same-line access must stay off the bus
            if ((ar_valid || aw_valid) && fast_q.size() != 0 && fast_q[0]) begin
                $display("AR or AW issued during a same-line access at %0t", $time);
                err_count++;
            end
            // responses first, an acceptance in the same edge is newer
            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("response without an outstanding request at %0t", $time);
                    err_count++;
                end else begin
                    e = exp_q.pop_front();
                    ld = load_q.pop_front();
                    fast = fast_q.pop_front();
                    c = cyc_q.pop_front();
                    check_count++;
                    if (ld && rdata !== e) begin
                        $display("ERROR rdata got %h expected %h", rdata, e);
                        err_count++;
                    end
                    if (fast && cycle != c + 1) begin
                        $display("same-line access took %0d cycles instead of one", cycle - c);
                        err_count++;
                    end
                end
            end
            if (req_valid && !stall) begin
                wa = {req.addr[31:2], 2'b00};
                if (req.write) model[wa] = apply_strobe(model_word(wa), req.wdata, req.strb);
                exp_q.push_back(model_word(wa));
                load_q.push_back(!req.write);
                fast_q.push_back(prev_ok && prev_line == (wa >> $clog2(LINE_BYTES)));
                cyc_q.push_back(cycle);
                prev_ok = 1'b1;
                prev_line = wa >> $clog2(LINE_BYTES);
            end
            if (ar_valid && ar_ready) begin
                check_count++;
                if (ar.addr % LINE_BYTES != 0 || ar.len != 8'(LINE_WORDS - 1)) begin
                    $display("ERROR ar addr %h len %h", ar.addr, ar.len);
                    err_count++;
                end
            end
            if (aw_valid && aw_ready) begin
                check_count++;
                wb_addr = aw.addr;
                wb_beat = 0;
                if (aw.addr % LINE_BYTES != 0 || aw.len != 8'(LINE_WORDS - 1)) begin
                    $display("ERROR aw addr %h len %h", aw.addr, aw.len);
                    err_count++;
                end
            end
            if (w_valid && w_ready) begin
                e = model_word(wb_addr + 4 * wb_beat);
                check_count++;
                if (w.data !== e || w.strb !== 4'hf) begin
                    $display("ERROR w.data got %h expected %h strb %h", w.data, e, w.strb);
                    err_count++;
                end
                if (w.last !== (wb_beat == LINE_WORDS - 1)) begin
                    $display("ERROR w.last got %h on beat %h", w.last, wb_beat);
                    err_count++;
                end
                wb_beat++;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int NUM_MIX = 300;
    localparam int NUM_PAIRS = 60;
    localparam int NUM_REQ = NUM_MIX + 4 * NUM_PAIRS;
    localparam int LINE_WORDS = 1 << DEF_LINE_WORDS_LOG;
    localparam logic [31:0] SEED = 32'h51954558;

    logic clk, rst, req_valid, stall, rsp_valid;
    cpu_req_t req;
    word_t rdata;
    logic ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
    logic w_valid, w_ready, b_valid;
    axi_addr_t ar, aw;
    axi_r_t r;
    axi_w_t w;
    int err_count, check_count, pending;
    int last_err, last_chk;
    logic [31:0] stim_lfsr, axi_lfsr;

    // slave side memory and burst tracking
    word_t mem [addr_t];
    addr_t rd_addr, wr_addr;
    int rd_beat, wr_beat;
    logic rd_active, b_pend;

    dcache_top dut_i (.*);

    dcache_checker chk_i (.*);

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
    endfunction

    function automatic logic [31:0] stim_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = stim_lfsr[0];
            stim_lfsr = lfsr_step(stim_lfsr);
        end
        return v;
    endfunction

    function automatic logic axi_bit();
        logic v;
        v = axi_lfsr[0];
        axi_lfsr = lfsr_step(axi_lfsr);
        return v;
    endfunction

    function automatic word_t mem_word(addr_t a);
        if (mem.exists(a)) return mem[a];
        return a ^ 32'hA5A5A5A5;
    endfunction

    // 4 sets x 3 tags
    function automatic addr_t rand_addr();
        logic [1:0] set, tag;
        logic [2:0] wd;
        set = 2'(stim_bits(2));
        tag = 2'(stim_bits(2));
        if (tag == 2'd3) tag = 2'd0;
        wd = 3'(stim_bits(3));
        return {20'(tag + 1), 7'(set), wd, 2'b00};
    endfunction

    task automatic send(addr_t a, logic wr, word_t d, strb_t s);
        req_valid = 1'b1;
        req.addr = a;
        req.wdata = d;
        req.strb = s;
        req.write = wr;
        do @(posedge clk); while (stall);
        #2;
    endtask

    task automatic finish_test(string name);
        req_valid = 1'b0;
        while (pending != 0) @(posedge clk);
        #2;
        $display("test %s done: %0d checks, %0d errors", name,
            check_count - last_chk, err_count - last_err);
        last_chk = check_count;
        last_err = err_count;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // AXI slave with random ready and valid gaps
    always @(posedge clk) begin
        logic r_fire;
        r_fire = r_valid && r_ready;
        if (ar_valid && ar_ready) begin
            rd_active = 1'b1;
            rd_addr = ar.addr;
            rd_beat = 0;
        end
        if (r_fire) begin
            rd_beat++;
            if (r.last) rd_active = 1'b0;
        end
        if (aw_valid && aw_ready) begin
            wr_addr = aw.addr;
            wr_beat = 0;
        end
        if (w_valid && w_ready) begin
            mem[wr_addr + 4 * wr_beat] = w.data;
            wr_beat++;
            if (w.last) b_pend = 1'b1;
        end
        if (b_valid) b_pend = 1'b0;
        #2;
        if (r_fire) r_valid = 1'b0;
        ar_ready = axi_bit();
        aw_ready = axi_bit();
        w_ready = axi_bit();
        b_valid = b_pend && axi_bit();
        if (rd_active && !r_valid) r_valid = axi_bit();
        r.data = rd_active ? mem_word(rd_addr + 4 * rd_beat) : '0;
        r.last = rd_active && rd_beat == LINE_WORDS - 1;
    end

    initial begin
        repeat (NUM_REQ * 200 + 64) @(posedge clk);
        $display("watchdog expired with %0d responses still missing", pending);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        addr_t a;
        logic wr;
        stim_lfsr = SEED;
        axi_lfsr = SEED;
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r = '0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        rd_active = 1'b0;
        b_pend = 1'b0;
        rd_addr = '0;
        wr_addr = '0;
        rd_beat = 0;
        wr_beat = 0;
        last_err = 0;
        last_chk = 0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        repeat (8) @(posedge clk);
        #2;
        finish_test("reset_idle");

        for (int i = 0; i < NUM_MIX; i++) begin
            a = rand_addr();
            wr = 1'(stim_bits(1));
            send(a, wr, stim_bits(32), 4'(stim_bits(4)));
        end
        finish_test("random_mix");

        for (int i = 0; i < NUM_PAIRS; i++) begin
            a = rand_addr();
            send(a, 1'b1, stim_bits(32), 4'(stim_bits(4)));
            send(a, 1'b0, '0, '0);
        end
        finish_test("strobe_store_load");

        for (int i = 0; i < NUM_PAIRS; i++) begin
            a = rand_addr();
            wr = 1'(stim_bits(1));
            send(a, wr, stim_bits(32), 4'hf);
            a = {a[31:5], 3'(stim_bits(3)), 2'b00};
            wr = 1'(stim_bits(1));
            send(a, wr, stim_bits(32), 4'(stim_bits(4)));
        end
        finish_test("same_line");

        $display("tests 4, checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
